// ==== src/exec_config.svh ====
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Datapath word width in bits
`define EXEC_XLEN 32

// Architectural register count, r0 to r15
`define EXEC_NREGS 16

`endif

// ==== src/armIsaPkg.sv ====
package armIsaPkg;

  // Data-processing opcodes in ARM encoding order
  typedef enum logic [3:0] {
    opAnd = 4'b0000,
    opEor = 4'b0001,
    opSub = 4'b0010,
    opRsb = 4'b0011,
    opAdd = 4'b0100,
    opAdc = 4'b0101,
    opSbc = 4'b0110,
    opRsc = 4'b0111,
    opTst = 4'b1000,
    opTeq = 4'b1001,
    opCmp = 4'b1010,
    opCmn = 4'b1011,
    opOrr = 4'b1100,
    opMov = 4'b1101,
    opBic = 4'b1110,
    opMvn = 4'b1111
  } dpOpcode;

  typedef enum logic [3:0] {
    condEq, condNe, condCs, condCc,
    condMi, condPl, condVs, condVc,
    condHi, condLs, condGe, condLt,
    condGt, condLe, condAl, condNv  // Nv never passes
  } condCode;

  typedef enum logic [1:0] {
    shLsl = 2'b00,
    shLsr = 2'b01,
    shAsr = 2'b10,
    shRor = 2'b11
  } shiftType;

  // I bit set, 8-bit immediate rotated right by 2*rotate
  typedef struct packed {
    condCode    cond;
    logic [1:0] opClass;   // 00 for data processing
    logic       immBit;
    dpOpcode    opcode;
    logic       sBit;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [3:0] rotate;
    logic [7:0] imm8;
  } dpImmInstr;

  // I bit clear, Rm shifted by a 5-bit immediate
  typedef struct packed {
    condCode    cond;
    logic [1:0] opClass;
    logic       immBit;
    dpOpcode    opcode;
    logic       sBit;
    logic [3:0] rn;
    logic [3:0] rd;
    logic [4:0] shiftAmt;
    shiftType   shType;
    logic       regShift;  // Set means shift by register, not supported
    logic [3:0] rm;
  } dpRegInstr;

  typedef union packed {
    dpImmInstr asImm;
    dpRegInstr asReg;
  } instrWord;

endpackage

// ==== src/execPkg.sv ====
`include "exec_config.svh"

package execPkg;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcvFlags;

  // Everything the ALU needs for one operation
  typedef struct packed {
    armIsaPkg::dpOpcode     opcode;
    logic [`EXEC_XLEN-1:0]  a;           // Rn value
    logic [`EXEC_XLEN-1:0]  b;           // Shifter output
    logic                   shiftCarry;
    nzcvFlags               oldFlags;
  } aluRequest;

  typedef struct packed {
    logic [$clog2(`EXEC_NREGS)-1:0] rd;
    logic [`EXEC_XLEN-1:0]          result;    // Zero unless executed
    logic                           written;   // Destination updated
    logic                           executed;  // Legal and condition passed
    logic                           illegal;
    nzcvFlags                       flags;     // Flags after the instruction
  } retireInfo;

endpackage

// ==== src/instrDecoder.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module instrDecoder (
  input  armIsaPkg::instrWord instr,
  output armIsaPkg::dpOpcode  opcode,
  output armIsaPkg::condCode  cond,
  output logic [3:0]          rn,
  output logic [3:0]          rd,
  output logic [3:0]          rm,
  output logic                immForm,
  output logic                setFlags,
  output logic                illegal
);

  logic [1:0] opClass;
  logic       regShift;
  logic       isCompare;

  assign immForm = instr.asImm.immBit;  // Same bit in both layouts

  always_comb begin
    if (immForm) begin
      cond     = instr.asImm.cond;
      opClass  = instr.asImm.opClass;
      opcode   = instr.asImm.opcode;
      setFlags = instr.asImm.sBit;
      rn       = instr.asImm.rn;
      rd       = instr.asImm.rd;
      rm       = 4'd0;     // No Rm in immediate form
      regShift = 1'b0;
    end else begin
      cond     = instr.asReg.cond;
      opClass  = instr.asReg.opClass;
      opcode   = instr.asReg.opcode;
      setFlags = instr.asReg.sBit;
      rn       = instr.asReg.rn;
      rd       = instr.asReg.rd;
      rm       = instr.asReg.rm;
      regShift = instr.asReg.regShift;
    end
  end

  assign isCompare = opcode inside {armIsaPkg::opTst, armIsaPkg::opTeq,
                                    armIsaPkg::opCmp, armIsaPkg::opCmn};

  // Other classes, register-shifted register, and compares without S
  assign illegal = (opClass != 2'b00) || regShift || (isCompare && !setFlags);

endmodule

// ==== src/regFile.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module regFile (
  input  logic                           clk,
  input  logic                           arstN,
  input  logic [$clog2(`EXEC_NREGS)-1:0] rdAddrA,
  input  logic [$clog2(`EXEC_NREGS)-1:0] rdAddrB,
  output logic [`EXEC_XLEN-1:0]          rdDataA,
  output logic [`EXEC_XLEN-1:0]          rdDataB,
  input  logic                           wrEn,
  input  logic [$clog2(`EXEC_NREGS)-1:0] wrAddr,
  input  logic [`EXEC_XLEN-1:0]          wrData
);

  logic [`EXEC_XLEN-1:0] regs [`EXEC_NREGS];

  // Architectural state starts at zero
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `EXEC_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Reads see the value before this edge's write
  assign rdDataA = regs[rdAddrA];
  assign rdDataB = regs[rdAddrB];

endmodule

// ==== src/barrelShifter.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module barrelShifter (
  input  armIsaPkg::instrWord   instr,
  input  logic                  immForm,
  input  logic [`EXEC_XLEN-1:0] rmData,
  input  logic                  carryIn,
  output logic [`EXEC_XLEN-1:0] operand,
  output logic                  carryOut
);

  logic [`EXEC_XLEN-1:0]   imm32;
  logic [`EXEC_XLEN-1:0]   immRot;
  logic [`EXEC_XLEN-1:0]   rorVal;
  logic [2*`EXEC_XLEN-1:0] immDbl;
  logic [2*`EXEC_XLEN-1:0] rorDbl;
  logic [4:0]              immAmt;
  logic [4:0]              amt;

  assign imm32  = {{(`EXEC_XLEN-8){1'b0}}, instr.asImm.imm8};
  assign immAmt = {instr.asImm.rotate, 1'b0};  // Even rotations only
  assign immDbl = {imm32, imm32} >> immAmt;
  assign immRot = immDbl[`EXEC_XLEN-1:0];

  assign amt    = instr.asReg.shiftAmt;
  assign rorDbl = {rmData, rmData} >> amt;
  assign rorVal = rorDbl[`EXEC_XLEN-1:0];

  always_comb begin
    operand  = rmData;
    carryOut = carryIn;
    if (immForm) begin
      operand  = immRot;
      carryOut = (immAmt != 5'd0) ? immRot[`EXEC_XLEN-1] : carryIn;
    end else begin
      case (instr.asReg.shType)
        armIsaPkg::shLsl: begin
          if (amt != 5'd0) begin  // LSL 0 keeps value and carry
            operand  = rmData << amt;
            carryOut = rmData[`EXEC_XLEN - amt];
          end
        end
        armIsaPkg::shLsr: begin
          if (amt == 5'd0) begin  // Encodes LSR 32
            operand  = '0;
            carryOut = rmData[`EXEC_XLEN-1];
          end else begin
            operand  = rmData >> amt;
            carryOut = rmData[amt - 1];
          end
        end
        armIsaPkg::shAsr: begin
          if (amt == 5'd0) begin  // Encodes ASR 32
            operand  = {`EXEC_XLEN{rmData[`EXEC_XLEN-1]}};
            carryOut = rmData[`EXEC_XLEN-1];
          end else begin
            operand  = $signed(rmData) >>> amt;
            carryOut = rmData[amt - 1];
          end
        end
        armIsaPkg::shRor: begin
          if (amt == 5'd0) begin  // RRX through the carry
            operand  = {carryIn, rmData[`EXEC_XLEN-1:1]};
            carryOut = rmData[0];
          end else begin
            operand  = rorVal;
            carryOut = rorVal[`EXEC_XLEN-1];
          end
        end
        default: begin
          operand  = rmData;
          carryOut = carryIn;
        end
      endcase
    end
  end

endmodule

// ==== src/flagUnit.sv ====
`timescale 1ns/1ps

module flagUnit (
  input  logic               clk,
  input  logic               arstN,
  input  armIsaPkg::condCode cond,
  output logic               passed,
  output execPkg::nzcvFlags  flags,
  input  execPkg::nzcvFlags  newFlags,
  input  logic               update
);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
    end else if (update) begin
      flags <= newFlags;
    end
  end

  // ARM condition table on the current flags
  always_comb begin
    case (cond)
      armIsaPkg::condEq: passed = flags.z;
      armIsaPkg::condNe: passed = !flags.z;
      armIsaPkg::condCs: passed = flags.c;
      armIsaPkg::condCc: passed = !flags.c;
      armIsaPkg::condMi: passed = flags.n;
      armIsaPkg::condPl: passed = !flags.n;
      armIsaPkg::condVs: passed = flags.v;
      armIsaPkg::condVc: passed = !flags.v;
      armIsaPkg::condHi: passed = flags.c && !flags.z;       // Unsigned higher
      armIsaPkg::condLs: passed = !flags.c || flags.z;
      armIsaPkg::condGe: passed = (flags.n == flags.v);      // Signed compares
      armIsaPkg::condLt: passed = (flags.n != flags.v);
      armIsaPkg::condGt: passed = !flags.z && (flags.n == flags.v);
      armIsaPkg::condLe: passed = flags.z || (flags.n != flags.v);
      armIsaPkg::condAl: passed = 1'b1;
      default:           passed = 1'b0;                      // 1111 never
    endcase
  end

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module alu (
  input  execPkg::aluRequest    request,
  output logic [`EXEC_XLEN-1:0] result,
  output execPkg::nzcvFlags     flagsOut,
  output logic                  doNotWriteReg
);

  logic                  swapInputs;
  logic                  invertB;
  logic                  isArith;
  logic                  addCarry;
  logic [`EXEC_XLEN-1:0] opA;
  logic [`EXEC_XLEN-1:0] opB;
  logic [`EXEC_XLEN-1:0] bIn;
  logic [`EXEC_XLEN:0]   sum;

  // Reverse subtracts compute b - a
  assign swapInputs = request.opcode inside {armIsaPkg::opRsb, armIsaPkg::opRsc};
  assign opA = swapInputs ? request.b : request.a;
  assign opB = swapInputs ? request.a : request.b;

  assign invertB = request.opcode inside {armIsaPkg::opSub, armIsaPkg::opRsb,
                                          armIsaPkg::opSbc, armIsaPkg::opRsc,
                                          armIsaPkg::opCmp};

  assign isArith = request.opcode inside {armIsaPkg::opSub, armIsaPkg::opRsb,
                                          armIsaPkg::opAdd, armIsaPkg::opAdc,
                                          armIsaPkg::opSbc, armIsaPkg::opRsc,
                                          armIsaPkg::opCmp, armIsaPkg::opCmn};

  always_comb begin
    case (request.opcode)
      armIsaPkg::opSub, armIsaPkg::opRsb, armIsaPkg::opCmp:
        addCarry = 1'b1;                  // Two's complement subtract
      armIsaPkg::opAdc, armIsaPkg::opSbc, armIsaPkg::opRsc:
        addCarry = request.oldFlags.c;    // Carry chaining
      default:
        addCarry = 1'b0;
    endcase
  end

  assign bIn = invertB ? ~opB : opB;
  assign sum = {1'b0, opA} + {1'b0, bIn} + {{`EXEC_XLEN{1'b0}}, addCarry};

  always_comb begin
    case (request.opcode)
      armIsaPkg::opAnd, armIsaPkg::opTst: result = opA & opB;
      armIsaPkg::opEor, armIsaPkg::opTeq: result = opA ^ opB;
      armIsaPkg::opOrr:                   result = opA | opB;
      armIsaPkg::opBic:                   result = opA & ~opB;
      armIsaPkg::opMov:                   result = request.b;
      armIsaPkg::opMvn:                   result = ~request.b;
      default:                            result = sum[`EXEC_XLEN-1:0];
    endcase
  end

  assign doNotWriteReg = request.opcode inside {armIsaPkg::opTst, armIsaPkg::opTeq,
                                                armIsaPkg::opCmp, armIsaPkg::opCmn};

  always_comb begin
    flagsOut.n = result[`EXEC_XLEN-1];
    flagsOut.z = (result == '0);
    if (isArith) begin
      flagsOut.c = sum[`EXEC_XLEN];
      // Same-sign inputs giving an opposite-sign sum
      flagsOut.v = (opA[`EXEC_XLEN-1] == bIn[`EXEC_XLEN-1]) &&
                   (sum[`EXEC_XLEN-1] != opA[`EXEC_XLEN-1]);
    end else begin
      flagsOut.c = request.shiftCarry;
      flagsOut.v = request.oldFlags.v;  // Logical ops keep V
    end
  end

endmodule

// ==== src/execUnit.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module execUnit (
  input  logic                clk,
  input  logic                arstN,
  input  logic                req,
  input  armIsaPkg::instrWord instr,
  output logic                ack,
  output execPkg::retireInfo  retire
);

  typedef enum logic {
    ctrlIdle,
    ctrlExec
  } ctrlState;

  ctrlState                state;
  armIsaPkg::instrWord     instrQ;
  armIsaPkg::dpOpcode      opcode;
  armIsaPkg::condCode      cond;
  logic [3:0]              rn;
  logic [3:0]              rd;
  logic [3:0]              rm;
  logic                    immForm;
  logic                    setFlags;
  logic                    illegal;
  logic [`EXEC_XLEN-1:0]   rnData;
  logic [`EXEC_XLEN-1:0]   rmData;
  logic [`EXEC_XLEN-1:0]   shOperand;
  logic                    shCarry;
  logic [`EXEC_XLEN-1:0]   aluResult;
  logic                    doNotWriteReg;
  logic                    passed;
  logic                    doExec;
  logic                    regWrEn;
  logic                    flagUpd;
  logic                    capture;
  execPkg::nzcvFlags       curFlags;
  execPkg::nzcvFlags       aluFlags;
  execPkg::aluRequest      aluReq;
  execPkg::retireInfo      retireNext;

  assign capture = (state == ctrlIdle) && req && !ack;  // New request seen

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state  <= ctrlIdle;
      ack    <= 1'b0;
      retire <= '0;
    end else begin
      case (state)
        ctrlIdle: begin
          if (capture) begin
            state <= ctrlExec;
          end else if (!req) begin
            ack <= 1'b0;  // Return to zero phase
          end
        end
        ctrlExec: begin
          ack    <= 1'b1;
          retire <= retireNext;
          state  <= ctrlIdle;
        end
        default: state <= ctrlIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      instrQ <= instr;
    end
  end

  instrDecoder dec0 (
    .instr    (instrQ),
    .opcode   (opcode),
    .cond     (cond),
    .rn       (rn),
    .rd       (rd),
    .rm       (rm),
    .immForm  (immForm),
    .setFlags (setFlags),
    .illegal  (illegal)
  );

  regFile rf0 (
    .clk     (clk),
    .arstN   (arstN),
    .rdAddrA (rn),
    .rdAddrB (rm),
    .rdDataA (rnData),
    .rdDataB (rmData),
    .wrEn    (regWrEn),
    .wrAddr  (rd),
    .wrData  (aluResult)
  );

  barrelShifter shift0 (
    .instr    (instrQ),
    .immForm  (immForm),
    .rmData   (rmData),
    .carryIn  (curFlags.c),
    .operand  (shOperand),
    .carryOut (shCarry)
  );

  assign aluReq = '{opcode:     opcode,
                    a:          rnData,
                    b:          shOperand,
                    shiftCarry: shCarry,
                    oldFlags:   curFlags};

  alu alu0 (
    .request       (aluReq),
    .result        (aluResult),
    .flagsOut      (aluFlags),
    .doNotWriteReg (doNotWriteReg)
  );

  flagUnit flags0 (
    .clk      (clk),
    .arstN    (arstN),
    .cond     (cond),
    .passed   (passed),
    .flags    (curFlags),
    .newFlags (aluFlags),
    .update   (flagUpd)
  );

  // Illegal or skipped instructions leave all state alone
  assign doExec  = !illegal && passed;
  assign regWrEn = (state == ctrlExec) && doExec && !doNotWriteReg;
  assign flagUpd = (state == ctrlExec) && doExec && setFlags;

  assign retireNext = '{rd:       rd,
                        result:   doExec ? aluResult : '0,
                        written:  regWrEn,
                        executed: doExec,
                        illegal:  illegal,
                        flags:    flagUpd ? aluFlags : curFlags};

endmodule

// ==== verif/execUnit_sva.sv ====
`timescale 1ns/1ps

module execUnit_sva (
  input logic               clk,
  input logic               arstN,
  input logic               req,
  input logic               ack,
  input execPkg::retireInfo retire
);

  int failCount = 0;  // Assertion failures so far

  ackLowAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !ack)
    else begin
      $error("ack high when reset is released");
      failCount++;
    end

  // A handshake starts only from the requester
  ackRiseNeedsReq: assert property (@(posedge clk) disable iff (!arstN)
    $rose(ack) |-> req)
    else begin
      $error("ack rose without req");
      failCount++;
    end

  ackHoldsWithReq: assert property (@(posedge clk) disable iff (!arstN)
    (ack && req) |=> ack)
    else begin
      $error("ack fell while req was still high");
      failCount++;
    end

  // Retire record only moves together with a rising ack
  retireHeldBetweenAcks: assert property (@(posedge clk) disable iff (!arstN)
    !$rose(ack) |-> $stable(retire))
    else begin
      $error("retire changed without a new ack");
      failCount++;
    end

endmodule

bind execUnit execUnit_sva sva0 (
  .clk    (clk),
  .arstN  (arstN),
  .req    (req),
  .ack    (ack),
  .retire (retire)
);

// ==== verif/execUnitTb.sv ====
`timescale 1ns/1ps
`include "exec_config.svh"

module execUnitTb;

  localparam int clkPeriod      = 20;
  localparam int resetCycles    = 10;
  localparam int cyclesPerInstr = 100;
  localparam armIsaPkg::condCode al = armIsaPkg::condAl;

  logic                  clk;
  logic                  arstN;
  logic                  req;
  armIsaPkg::instrWord   instr;
  logic                  ack;
  execPkg::retireInfo    retire;

  logic [31:0]           lfsrState;
  logic [`EXEC_XLEN-1:0] modelRegs [`EXEC_NREGS];  // Reference copy of the register file
  execPkg::nzcvFlags     modelFlags;
  int                    issued = 0;

  execUnit dut0 (
    .clk    (clk),
    .arstN  (arstN),
    .req    (req),
    .instr  (instr),
    .ack    (ack),
    .retire (retire)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  task automatic failRun(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic checkRetire(input string name, input execPkg::retireInfo exp,
                             input execPkg::retireInfo act);
    if (act !== exp) begin
      failRun($sformatf("FAIL %s: retire expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkFlags(input string name, input execPkg::nzcvFlags exp,
                            input execPkg::nzcvFlags act);
    if (act !== exp) begin
      failRun($sformatf("FAIL %s: NZCV expected %b, actual %b", name, exp, act));
    end
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic lfsrStep();
    logic fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsrStep()};
    end
    return v;
  endfunction

  function automatic logic [31:0] rotr(input logic [31:0] v, input int amt);
    return (v >> amt) | (v << ((32 - amt) % 32));
  endfunction

  function automatic armIsaPkg::instrWord immWord(input armIsaPkg::condCode cond,
      input armIsaPkg::dpOpcode op, input logic s, input logic [3:0] rn,
      input logic [3:0] rd, input logic [3:0] rot, input logic [7:0] imm8);
    return {cond, 2'b00, 1'b1, op, s, rn, rd, rot, imm8};
  endfunction

  function automatic armIsaPkg::instrWord regWord(input armIsaPkg::condCode cond,
      input armIsaPkg::dpOpcode op, input logic s, input logic [3:0] rn,
      input logic [3:0] rd, input logic [4:0] amt, input armIsaPkg::shiftType sh,
      input logic [3:0] rm);
    return {cond, 2'b00, 1'b0, op, s, rn, rd, amt, sh, 1'b0, rm};
  endfunction

  // Cond pairs share a base test, odd codes invert it
  function automatic logic condHolds(input logic [3:0] cond, input execPkg::nzcvFlags f);
    logic base;
    case (cond[3:1])
      3'd0:    base = f.z;
      3'd1:    base = f.c;
      3'd2:    base = f.n;
      3'd3:    base = f.v;
      3'd4:    base = f.c & ~f.z;
      3'd5:    base = (f.n == f.v);
      3'd6:    base = ~f.z & (f.n == f.v);
      default: base = 1'b1;
    endcase
    if (cond[3:1] == 3'd7) begin
      return !cond[0];  // AL passes, NV never
    end
    return base ^ cond[0];
  endfunction

  task automatic addWithCarry(input logic [31:0] x, input logic [31:0] y, input logic cin,
                              output logic [31:0] r, output logic c, output logic v);
    logic [32:0] usum;
    longint      ssum;
    usum = {1'b0, x} + {1'b0, y} + 33'(cin);
    ssum = longint'($signed(x)) + longint'($signed(y)) + longint'(cin);
    r = usum[31:0];
    c = usum[32];
    v = (ssum != longint'($signed(r)));  // Signed result out of range
  endtask

  task automatic shiftModel(input logic [31:0] w, output logic [31:0] op2, output logic c);
    logic [31:0] rmv;
    logic [5:0]  n;
    logic [32:0] t;
    rmv = modelRegs[w[3:0]];
    n   = (w[11:7] == 5'd0) ? 6'd32 : {1'b0, w[11:7]};  // Zero amount means 32
    c   = modelFlags.c;
    op2 = rmv;
    if (w[25]) begin
      op2 = rotr(32'(w[7:0]), 2 * w[11:8]);
      if (w[11:8] != 4'd0) begin
        c = op2[31];
      end
    end else begin
      case (w[6:5])
        2'b00: begin
          if (w[11:7] != 5'd0) begin
            {c, op2} = {1'b0, rmv} << w[11:7];
          end
        end
        2'b01: begin
          t   = {rmv, 1'b0} >> n;  // Bit 0 catches the last bit out
          op2 = t[32:1];
          c   = t[0];
        end
        2'b10: begin
          t   = $signed({rmv, 1'b0}) >>> n;
          op2 = t[32:1];
          c   = t[0];
        end
        default: begin
          if (w[11:7] == 5'd0) begin
            op2 = {modelFlags.c, rmv[31:1]};  // RRX
            c   = rmv[0];
          end else begin
            op2 = rotr(rmv, w[11:7]);
            c   = op2[31];
          end
        end
      endcase
    end
  endtask

  // Expected retire record, and the model state moves on
  task automatic predict(input armIsaPkg::instrWord instrIn, output execPkg::retireInfo exp);
    logic [31:0]        w;
    armIsaPkg::dpOpcode op;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        r;
    logic               c;
    logic               v;
    logic               isCmp;
    logic               bad;
    logic               run;
    execPkg::nzcvFlags  nf;
    w     = instrIn;
    op    = armIsaPkg::dpOpcode'(w[24:21]);
    isCmp = (w[24:23] == 2'b10);
    bad   = (w[27:26] != 2'b00) || (!w[25] && w[4]) || (isCmp && !w[20]);
    run   = !bad && condHolds(w[31:28], modelFlags);
    a     = modelRegs[w[19:16]];
    shiftModel(w, b, c);
    v     = modelFlags.v;
    case (op)
      armIsaPkg::opAnd, armIsaPkg::opTst: r = a & b;
      armIsaPkg::opEor, armIsaPkg::opTeq: r = a ^ b;
      armIsaPkg::opSub, armIsaPkg::opCmp: addWithCarry(a, ~b, 1'b1, r, c, v);
      armIsaPkg::opRsb:                   addWithCarry(b, ~a, 1'b1, r, c, v);
      armIsaPkg::opAdd, armIsaPkg::opCmn: addWithCarry(a, b, 1'b0, r, c, v);
      armIsaPkg::opAdc:                   addWithCarry(a, b, modelFlags.c, r, c, v);
      armIsaPkg::opSbc:                   addWithCarry(a, ~b, modelFlags.c, r, c, v);
      armIsaPkg::opRsc:                   addWithCarry(b, ~a, modelFlags.c, r, c, v);
      armIsaPkg::opOrr:                   r = a | b;
      armIsaPkg::opMov:                   r = b;
      armIsaPkg::opBic:                   r = a & ~b;
      default:                            r = ~b;
    endcase
    nf = '{n: r[31], z: (r == 32'd0), c: c, v: v};
    exp.rd       = w[15:12];
    exp.result   = run ? r : '0;
    exp.written  = run && !isCmp;
    exp.executed = run;
    exp.illegal  = bad;
    exp.flags    = (run && w[20]) ? nf : modelFlags;
    if (exp.written) begin
      modelRegs[w[15:12]] = r;
    end
    modelFlags = exp.flags;
  endtask

  // One four-phase handshake
  task automatic issueInstr(input armIsaPkg::instrWord w, output execPkg::retireInfo r);
    issued++;
    @(posedge clk);
    req   <= 1'b1;
    instr <= w;
    do @(negedge clk); while (!ack);
    r = retire;  // Valid while ack is high
    @(posedge clk);
    req <= 1'b0;
    do @(negedge clk); while (ack);
  endtask

  task automatic runInstr(input string name, input armIsaPkg::instrWord w);
    execPkg::retireInfo exp;
    execPkg::retireInfo act;
    predict(w, exp);
    issueInstr(w, act);
    checkRetire(name, exp, act);
  endtask

  // MOV then three ORRs with rotated bytes
  task automatic loadReg(input logic [3:0] rd, input logic [31:0] value);
    runInstr("load", immWord(al, armIsaPkg::opMov, 1'b0, 4'd0, rd, 4'd0, value[7:0]));
    runInstr("load", immWord(al, armIsaPkg::opOrr, 1'b0, rd, rd, 4'd12, value[15:8]));
    runInstr("load", immWord(al, armIsaPkg::opOrr, 1'b0, rd, rd, 4'd8, value[23:16]));
    runInstr("load", immWord(al, armIsaPkg::opOrr, 1'b0, rd, rd, 4'd4, value[31:24]));
  endtask

  task automatic testReset();
    if (ack !== 1'b0) begin
      failRun("ack is not low after reset");
    end
    for (int i = 0; i < `EXEC_NREGS; i++) begin
      runInstr("reset", immWord(al, armIsaPkg::opAdd, 1'b0, 4'(i), 4'(i), 4'd0, 8'd0));
      checkFlags("reset", '0, retire.flags);
    end
  endtask

  task automatic testArith();
    logic [31:0] x;
    logic [31:0] y;
    for (int round = 0; round < 6; round++) begin
      x = randBits(32);
      y = randBits(32);
      if (round == 0) begin
        x = 32'h7FFF_FFFF;  // Signed overflow
        y = 32'h0000_0001;
      end else if (round == 1) begin
        x = 32'hFFFF_FFFF;  // Unsigned carry out
        y = 32'h0000_0001;
      end else if (round == 2) begin
        y = x;              // Zero difference
      end
      loadReg(4'd1, x);
      loadReg(4'd2, y);
      runInstr("adds", regWord(al, armIsaPkg::opAdd, 1'b1, 4'd1, 4'd3, 5'd0,
                               armIsaPkg::shLsl, 4'd2));
      runInstr("subs", regWord(al, armIsaPkg::opSub, 1'b1, 4'd1, 4'd4, 5'd0,
                               armIsaPkg::shLsl, 4'd2));
      runInstr("rsbs", regWord(al, armIsaPkg::opRsb, 1'b1, 4'd1, 4'd5, 5'd0,
                               armIsaPkg::shLsl, 4'd2));
      runInstr("adcs", regWord(al, armIsaPkg::opAdc, 1'b1, 4'd1, 4'd6, 5'd0,
                               armIsaPkg::shLsl, 4'd2));
      runInstr("sbcs", regWord(al, armIsaPkg::opSbc, 1'b1, 4'd1, 4'd7, 5'd0,
                               armIsaPkg::shLsl, 4'd2));
      runInstr("rscs", regWord(al, armIsaPkg::opRsc, 1'b1, 4'd1, 4'd8, 5'd0,
                               armIsaPkg::shLsl, 4'd2));
      runInstr("adds imm", immWord(al, armIsaPkg::opAdd, 1'b1, 4'd1, 4'd9,
                                   4'(randBits(4)), 8'(randBits(8))));
    end
  endtask

  task automatic testLogic();
    logic [4:0] amt;
    for (int round = 0; round < 3; round++) begin
      loadReg(4'd1, 32'h7FFF_FFFF);
      runInstr("set v", immWord(al, armIsaPkg::opAdd, 1'b1, 4'd1, 4'd3, 4'd0, 8'd1));
      loadReg(4'd1, randBits(32));
      loadReg(4'd2, randBits(32));
      amt = 5'(randBits(5)) | 5'd1;
      runInstr("ands", regWord(al, armIsaPkg::opAnd, 1'b1, 4'd1, 4'd4, amt,
                               armIsaPkg::shLsr, 4'd2));
      runInstr("eors", regWord(al, armIsaPkg::opEor, 1'b1, 4'd1, 4'd5, amt,
                               armIsaPkg::shAsr, 4'd2));
      runInstr("orrs", immWord(al, armIsaPkg::opOrr, 1'b1, 4'd1, 4'd6,
                               4'(randBits(4)) | 4'd1, 8'(randBits(8))));
      runInstr("bics", regWord(al, armIsaPkg::opBic, 1'b1, 4'd1, 4'd7, amt,
                               armIsaPkg::shRor, 4'd2));
      runInstr("mvns", regWord(al, armIsaPkg::opMvn, 1'b1, 4'd0, 4'd8, amt,
                               armIsaPkg::shLsl, 4'd2));
      runInstr("tst", regWord(al, armIsaPkg::opTst, 1'b1, 4'd1, 4'd12, amt,
                              armIsaPkg::shLsl, 4'd2));
      runInstr("teq", immWord(al, armIsaPkg::opTeq, 1'b1, 4'd1, 4'd12, 4'd4, 8'(randBits(8))));
      runInstr("cmp", regWord(al, armIsaPkg::opCmp, 1'b1, 4'd1, 4'd12, 5'd0,
                              armIsaPkg::shLsl, 4'd2));
      runInstr("cmn", regWord(al, armIsaPkg::opCmn, 1'b1, 4'd1, 4'd12, 5'd0,
                              armIsaPkg::shLsl, 4'd2));
    end
  endtask

  task automatic testShifts();
    logic [4:0] amt;
    for (int v = 0; v < 3; v++) begin
      loadReg(4'd1, (v == 0) ? 32'h8000_0001 : randBits(32));
      for (int t = 0; t < 4; t++) begin
        for (int k = 0; k < 4; k++) begin
          case (k)
            0:       amt = 5'd0;   // LSR 32, ASR 32, RRX
            1:       amt = 5'd1;
            2:       amt = 5'd31;
            default: amt = 5'(randBits(5)) | 5'd1;
          endcase
          runInstr("shift", regWord(al, armIsaPkg::opMov, 1'b1, 4'd0, 4'd10, amt,
                                    armIsaPkg::shiftType'(t), 4'd1));
        end
      end
    end
  endtask

  task automatic testCond();
    logic [31:0]        xs [6];
    logic [31:0]        ys [6];
    armIsaPkg::dpOpcode ops [6];
    execPkg::nzcvFlags  fl [6];
    logic [31:0]        illegalWords [6];
    execPkg::nzcvFlags  savedFlags;
    xs  = '{32'd5, 32'd0, 32'h7FFF_FFFF, 32'h8000_0000, 32'd2, 32'h8000_0000};
    ys  = '{32'd5, 32'd1, 32'd1, 32'h8000_0000, 32'd1, 32'd1};
    ops = '{armIsaPkg::opCmp, armIsaPkg::opCmp, armIsaPkg::opAdd,
            armIsaPkg::opCmn, armIsaPkg::opCmp, armIsaPkg::opCmp};
    fl  = '{4'b0110, 4'b1000, 4'b1001, 4'b0111, 4'b0010, 4'b0011};
    for (int s = 0; s < 6; s++) begin
      loadReg(4'd1, xs[s]);
      loadReg(4'd2, ys[s]);
      runInstr("cond setup", regWord(al, ops[s], 1'b1, 4'd1, 4'd3, 5'd0,
                                     armIsaPkg::shLsl, 4'd2));
      checkFlags("cond setup", fl[s], retire.flags);
      for (int c = 0; c < 16; c++) begin
        runInstr("cond", immWord(armIsaPkg::condCode'(c), armIsaPkg::opAdd, 1'b0,
                                 4'd11, 4'd11, 4'd0, 8'd1));
      end
    end
    // Load, branch, multiply, shift by register, compares without S, class 11
    illegalWords = '{32'hE591_2000, 32'hEA00_0000, 32'hE000_0291,
                     32'hE081_2312, 32'hE140_0001, 32'hFF00_0000};
    savedFlags = modelFlags;
    for (int i = 0; i < 6; i++) begin
      runInstr("illegal", illegalWords[i]);
      checkFlags("illegal", savedFlags, retire.flags);
    end
    for (int r = 0; r < 4; r++) begin
      runInstr("readback", immWord(al, armIsaPkg::opAdd, 1'b0, 4'(r), 4'(r), 4'd0, 8'd0));
    end
  endtask

  // Limit grows with every issued instruction
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= resetCycles + cyclesPerInstr * (issued + 1)) begin
      @(posedge clk);
      cycles++;
    end
    failRun($sformatf("Timeout: handshake stalled after %0d instructions", issued));
  end

  // Bound assertion failures end the run at once
  initial begin
    wait (dut0.sva0.failCount != 0);
    failRun("A bound assertion on the handshake or retire record failed");
  end

  initial begin
    lfsrState  = 32'h6585;
    modelFlags = '0;
    for (int i = 0; i < `EXEC_NREGS; i++) begin
      modelRegs[i] = '0;
    end
    arstN = 1'b0;
    req   = 1'b0;
    instr = '0;
    repeat (resetCycles) @(posedge clk);
    arstN <= 1'b1;
    @(negedge clk);
    testReset();
    testArith();
    testLogic();
    testShifts();
    testCond();
    $display("** PASS **");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+src
src/armIsaPkg.sv
src/execPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/barrelShifter.sv
src/flagUnit.sv
src/alu.sv
src/execUnit.sv
verif/execUnit_sva.sv
verif/execUnitTb.sv

// ==== Bender.yml ====
package:
  name: exec_unit

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/armIsaPkg.sv
      - src/execPkg.sv
      - src/instrDecoder.sv
      - src/regFile.sv
      - src/barrelShifter.sv
      - src/flagUnit.sv
      - src/alu.sv
      - src/execUnit.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - verif/execUnit_sva.sv
      - verif/execUnitTb.sv
